/* design/ex_alu.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Combinational ALU for all ALU-op classes
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ex_alu #(
  parameter int XLEN = ex_pkg::XLEN_DEF
) (
  input  logic [XLEN-1:0] i_npc,
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  input  logic [XLEN-1:0] i_imm,
  input  ex_pkg::alu_op_e i_aluop,
  input  logic [2:0]      i_func3,
  input  logic            i_func7,
  output logic [XLEN-1:0] o_result
);
  import ex_pkg::*;

  localparam int SHAMT_W = $clog2(XLEN);        // Five bits on RV32

  logic [XLEN-1:0]    pc_rel;                   // npc plus half-word offset
  logic [XLEN-1:0]    base_sum;                 // rs1 plus imm
  logic [SHAMT_W-1:0] shamt;
  logic               is_sub;
  logic [XLEN-1:0]    arith;                    // RTYPE/ITYPE result

  assign pc_rel   = i_npc + (i_imm << 1);
  assign base_sum = i_a + i_imm;
  assign shamt    = i_b[SHAMT_W-1:0];           // Upper bits ignored
  assign is_sub   = (i_aluop == RTYPE) && i_func7; // No SUBI form

  always_comb
  begin
    case (i_func3)
      F3_ADD:
      begin
        if (is_sub)
          arith = i_a - i_b;
        else
          arith = i_a + i_b;
      end
      F3_SLL:
        arith = i_a << shamt;
      F3_SLT:
        arith = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      F3_SLTU:
        arith = {{(XLEN-1){1'b0}}, i_a < i_b};
      F3_XOR:
        arith = i_a ^ i_b;
      F3_SR:
      begin
        if (i_func7)
          arith = $signed(i_a) >>> shamt;       // SRA/SRAI, sign fill
        else
          arith = i_a >> shamt;                 // SRL/SRLI, zero fill
      end
      F3_OR:
        arith = i_a | i_b;
      F3_AND:
        arith = i_a & i_b;
      default:
        arith = '0;
    endcase
  end

  // Final result by instruction class
  always_comb
  begin
    case (i_aluop)
      LDST:
        o_result = base_sum;                    // Effective address
      BRANCH, AUIPC, JAL:
        o_result = pc_rel;
      RTYPE, ITYPE:
        o_result = arith;
      LUI:
        o_result = i_imm;                       // Imm arrives pre-shifted
      JALR:
        o_result = {base_sum[XLEN-1:1], 1'b0};  // Clear bit 0
      default:
        o_result = '0;
    endcase
  end

endmodule

/* design/ex_branch_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Branch compare, target and wrong-path squash
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ex_branch_unit #(
  parameter int XLEN = ex_pkg::XLEN_DEF
) (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_valid,
  input  logic [XLEN-1:0] i_npc,
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  input  logic [XLEN-1:0] i_imm,
  input  ex_pkg::alu_op_e i_aluop,
  input  logic [2:0]      i_func3,
  output logic            o_keep,
  output logic            o_taken,
  output logic [XLEN-1:0] o_target
);
  import ex_pkg::*;

  logic            cond;                        // Raw compare outcome
  logic            armed;                       // Waiting for branch target
  logic [XLEN-1:0] target_q;                    // Target being waited for

  always_comb
  begin
    case (i_func3)
      F3_BEQ:  cond = (i_a == i_b);
      F3_BNE:  cond = (i_a != i_b);
      F3_BLT:  cond = $signed(i_a) < $signed(i_b);
      F3_BGE:  cond = $signed(i_a) >= $signed(i_b);
      F3_BLTU: cond = i_a < i_b;
      F3_BGEU: cond = i_a >= i_b;
      default: cond = 1'b0;                     // Reserved codes fall through
    endcase
  end

  assign o_target = i_npc + (i_imm << 1);
  // Wrong-path instructions dropped until npc hits the stored target
  assign o_keep   = i_valid && (!armed || (i_npc == target_q));
  assign o_taken  = o_keep && (i_aluop == BRANCH) && cond;

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
      armed <= 1'b0;
    else if (o_taken)
      armed <= 1'b1;                            // Target instr may re-arm
    else if (o_keep && armed)
      armed <= 1'b0;                            // Target reached
  end

  always_ff @(posedge i_clk)
  begin
    if (o_taken)
      target_q <= o_target;
  end

endmodule

/* design/ex_mem_reg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// EX/MEM pipeline register
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ex_mem_reg #(
  parameter int XLEN = ex_pkg::XLEN_DEF
) (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_keep,
  input  logic [XLEN-1:0]               i_result,
  input  logic                          i_taken,
  input  logic [XLEN-1:0]               i_target,
  input  logic [XLEN-1:0]               i_store_data,
  input  logic [ex_pkg::REG_ADDR_W-1:0] i_rd,
  output logic                          o_valid,
  output logic [XLEN-1:0]               o_result,
  output logic                          o_branch_taken,
  output logic [XLEN-1:0]               o_branch_target,
  output logic [XLEN-1:0]               o_store_data,
  output logic [ex_pkg::REG_ADDR_W-1:0] o_rd
);

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
    begin
      o_valid        <= 1'b0;
      o_branch_taken <= 1'b0;
    end
    else
    begin
      o_valid        <= i_keep;                 // Squashed slot stays low
      o_branch_taken <= i_keep && i_taken;
    end
  end

  // Payload holds its last kept value
  always_ff @(posedge i_clk)
  begin
    if (i_keep)
    begin
      o_result        <= i_result;
      o_branch_target <= i_target;
      o_store_data    <= i_store_data;
      o_rd            <= i_rd;
    end
  end

endmodule

/* design/ex_operand_latch.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Input register of the execute stage, operand B select
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ex_operand_latch #(
  parameter int XLEN = ex_pkg::XLEN_DEF
) (
  input  logic                         i_clk,
  input  logic                         i_rst_n,
  input  logic                         i_valid,
  input  logic [XLEN-1:0]              i_npc,
  input  logic [XLEN-1:0]              i_rs1,
  input  logic [XLEN-1:0]              i_rs2,
  input  logic [XLEN-1:0]              i_imm,
  input  ex_pkg::alu_op_e              i_aluop,
  input  logic [2:0]                   i_func3,
  input  logic                         i_func7,
  input  logic [ex_pkg::REG_ADDR_W-1:0] i_rd,
  output logic                         o_valid,
  output logic [XLEN-1:0]              o_npc,
  output logic [XLEN-1:0]              o_a,
  output logic [XLEN-1:0]              o_b,
  output logic [XLEN-1:0]              o_rs2,
  output logic [XLEN-1:0]              o_imm,
  output ex_pkg::alu_op_e              o_aluop,
  output logic [2:0]                   o_func3,
  output logic                         o_func7,
  output logic [ex_pkg::REG_ADDR_W-1:0] o_rd
);
  import ex_pkg::*;

  logic b_sel;                                  // High picks rs2 over imm

  assign b_sel = (i_aluop == RTYPE) || (i_aluop == BRANCH); // Reg compare/arith

  always_ff @(posedge i_clk)
  begin
    if (!i_rst_n)
      o_valid <= 1'b0;
    else
      o_valid <= i_valid;                       // One cycle strobe
  end

  // Operand payload, sampled every cycle
  always_ff @(posedge i_clk)
  begin
    o_npc   <= i_npc;
    o_a     <= i_rs1;
    o_b     <= b_sel ? i_rs2 : i_imm;           // Operand B mux
    o_rs2   <= i_rs2;                           // Store data path
    o_imm   <= i_imm;
    o_aluop <= i_aluop;
    o_func3 <= i_func3;
    o_func7 <= i_func7;
    o_rd    <= i_rd;
  end

endmodule

/* design/ex_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Shared execute stage types: ALU-op classes, func3 codes, widths
// ~~~~~~~~~~~~~~~~~~~~

package ex_pkg;

  localparam int XLEN_DEF   = 32;             // Default data path width
  localparam int REG_ADDR_W = 5;              // Destination register index

  // Instruction class from decode
  typedef enum logic [2:0] {
    LDST   = 3'd0,                            // Load/store address
    BRANCH = 3'd1,                            // Conditional branch
    RTYPE  = 3'd2,                            // Reg-reg arithmetic
    ITYPE  = 3'd3,                            // Reg-imm arithmetic
    LUI    = 3'd4,
    AUIPC  = 3'd5,
    JAL    = 3'd6,
    JALR   = 3'd7
  } alu_op_e;

  // Branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Arithmetic operations, shared by reg and imm forms
  localparam logic [2:0] F3_ADD  = 3'b000;    // ADD/SUB
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;    // SRL/SRA by func7
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

endpackage

/* design/ex_stage.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Execute stage top: latch, ALU, branch unit, EX/MEM register
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ex_stage #(
  parameter int XLEN = ex_pkg::XLEN_DEF
) (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  input  logic                          i_valid,
  input  logic [XLEN-1:0]               i_npc,
  input  logic [XLEN-1:0]               i_rs1,
  input  logic [XLEN-1:0]               i_rs2,
  input  logic [XLEN-1:0]               i_imm,
  input  ex_pkg::alu_op_e               i_aluop,
  input  logic [2:0]                    i_func3,
  input  logic                          i_func7,
  input  logic [ex_pkg::REG_ADDR_W-1:0] i_rd,
  output logic                          o_valid,
  output logic [XLEN-1:0]               o_result,
  output logic                          o_branch_taken,
  output logic [XLEN-1:0]               o_branch_target,
  output logic [XLEN-1:0]               o_store_data,
  output logic [ex_pkg::REG_ADDR_W-1:0] o_rd
);
  import ex_pkg::*;

  logic                  lat_valid;             // Latched instruction
  logic [XLEN-1:0]       lat_npc;
  logic [XLEN-1:0]       lat_a;
  logic [XLEN-1:0]       lat_b;
  logic [XLEN-1:0]       lat_rs2;
  logic [XLEN-1:0]       lat_imm;
  alu_op_e               lat_aluop;
  logic [2:0]            lat_func3;
  logic                  lat_func7;
  logic [REG_ADDR_W-1:0] lat_rd;
  logic [XLEN-1:0]       alu_result;
  logic                  br_keep;               // Right-path flag
  logic                  br_taken;
  logic [XLEN-1:0]       br_target;

  ex_operand_latch #(.XLEN(XLEN)) u_latch (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_npc(i_npc),
    .i_rs1(i_rs1), .i_rs2(i_rs2), .i_imm(i_imm), .i_aluop(i_aluop),
    .i_func3(i_func3), .i_func7(i_func7), .i_rd(i_rd),
    .o_valid(lat_valid), .o_npc(lat_npc), .o_a(lat_a), .o_b(lat_b),
    .o_rs2(lat_rs2), .o_imm(lat_imm), .o_aluop(lat_aluop),
    .o_func3(lat_func3), .o_func7(lat_func7), .o_rd(lat_rd)
  );

  ex_alu #(.XLEN(XLEN)) u_alu (
    .i_npc(lat_npc), .i_a(lat_a), .i_b(lat_b), .i_imm(lat_imm),
    .i_aluop(lat_aluop), .i_func3(lat_func3), .i_func7(lat_func7),
    .o_result(alu_result)
  );

  ex_branch_unit #(.XLEN(XLEN)) u_branch (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(lat_valid), .i_npc(lat_npc),
    .i_a(lat_a), .i_b(lat_b), .i_imm(lat_imm), .i_aluop(lat_aluop),
    .i_func3(lat_func3), .o_keep(br_keep), .o_taken(br_taken),
    .o_target(br_target)
  );

  ex_mem_reg #(.XLEN(XLEN)) u_ex_mem (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_keep(br_keep),
    .i_result(alu_result), .i_taken(br_taken), .i_target(br_target),
    .i_store_data(lat_rs2), .i_rd(lat_rd),
    .o_valid(o_valid), .o_result(o_result), .o_branch_taken(o_branch_taken),
    .o_branch_target(o_branch_target), .o_store_data(o_store_data),
    .o_rd(o_rd)
  );

endmodule

/* ex_stage.f */
design/ex_pkg.sv
design/ex_operand_latch.sv
design/ex_alu.sv
design/ex_branch_unit.sv
design/ex_mem_reg.sv
design/ex_stage.sv
verif/ex_stage_tb.sv

/* verif/ex_stage_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// Execute stage testbench: reference model, LFSR stimulus, output checks
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module ex_stage_tb;
  import ex_pkg::*;

  localparam int          XLEN       = XLEN_DEF;
  localparam int          RST_CYC    = 4;
  localparam int          DRAIN      = 4;           // Idle cycles closing each test
  localparam int          N_ALU      = 48;
  localparam int          N_OTHER    = 20;
  localparam int          N_BR       = 48;          // 8 func3 x 6 operand pairs
  localparam int          TEST_CYC   = RST_CYC + 4 + N_ALU + N_OTHER + N_BR + 12 + 6 * DRAIN;
  localparam int          MAX_CYC    = TEST_CYC + 40; // Margin for drain and slack
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            taken;
    logic            is_br;                         // Target compared only for branches
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] store;
    logic [4:0]      rd;
    logic [31:0]     cyc;                           // Cycle the output is due
  } exp_t;

  logic clk;
  logic rst_n;
  logic valid;
  logic [XLEN-1:0] npc, rs1, rs2, imm;
  alu_op_e aluop;
  logic [2:0] func3;
  logic func7;
  logic [4:0] rd;
  logic o_valid, o_branch_taken;
  logic [XLEN-1:0] o_result, o_branch_target, o_store_data;
  logic [4:0] o_rd;

  exp_t exp_q[$];
  logic [31:0] lfsr_q = 32'd98;
  logic [31:0] cyc_count = 0;
  logic armed_m = 1'b0;                             // Model squash state
  logic [XLEN-1:0] target_m = '0;
  logic [XLEN-1:0] pc_m = 32'h0000_1000;            // Model next fetch address
  int n_checks = 0, n_errors = 0, chk0 = 0, err0 = 0;
  logic [XLEN-1:0] pa[6], pb[6];
  alu_op_e others[5];

  ex_stage #(.XLEN(XLEN)) dut0 (
    .i_clk(clk), .i_rst_n(rst_n), .i_valid(valid), .i_npc(npc), .i_rs1(rs1),
    .i_rs2(rs2), .i_imm(imm), .i_aluop(aluop), .i_func3(func3), .i_func7(func7),
    .i_rd(rd), .o_valid(o_valid), .o_result(o_result), .o_branch_taken(o_branch_taken),
    .o_branch_target(o_branch_target), .o_store_data(o_store_data), .o_rd(o_rd)
  );

  always #50 clk = ~clk;                            // 100 ns period

  always @(posedge clk)
  begin
    cyc_count = cyc_count + 1;
    if (cyc_count > MAX_CYC)
    begin
      $display("Timeout after %0d cycles, outputs still pending: %0d", cyc_count, exp_q.size());
      $display("Simulation failed");
      $finish;
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic logic [XLEN-1:0] sext12(input logic [31:0] v);
    return {{20{v[11]}}, v[11:0]};
  endfunction

  function automatic logic branch_cond(input logic [2:0] f3, input logic [XLEN-1:0] a, b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return !($signed(a) < $signed(b));
      F3_BLTU: return a < b;
      F3_BGEU: return !(a < b);
      default: return 1'b0;                         // Unused codes never branch
    endcase
  endfunction

  // Expected ALU result from the per-class rules
  function automatic logic [XLEN-1:0] model_result(input logic [XLEN-1:0] pc, a, r2, im,
                                                   input alu_op_e op, input logic [2:0] f3,
                                                   input logic f7);
    logic [XLEN-1:0] b, r;
    logic [4:0] sh;
    b = (op == RTYPE || op == BRANCH) ? r2 : im;
    sh = b[4:0];
    case (op)
      LDST:               return a + im;
      BRANCH, AUIPC, JAL: return pc + {im[XLEN-2:0], 1'b0};
      LUI:                return im;
      JALR:               return (a + im) & ~32'd1;
      default:
      begin
        case (f3)
          F3_ADD:  r = (op == RTYPE && f7) ? a + ~b + 1 : a + b;
          F3_SLL:  r = a << sh;
          F3_SLT:  r = ($signed(a) < $signed(b)) ? 1 : 0;
          F3_SLTU: r = (a < b) ? 1 : 0;
          F3_XOR:  r = a ^ b;
          F3_SR:   r = (f7 && a[XLEN-1]) ? (a >> sh) | ~({XLEN{1'b1}} >> sh) : a >> sh;
          F3_OR:   r = a | b;
          default: r = a & b;
        endcase
        return r;
      end
    endcase
  endfunction

  task automatic value_error(input string sig, input logic [XLEN-1:0] exp, got);
    $display("error at %0t: %s expected %h got %h", $time, sig, exp, got);
    n_errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("failure at %0t: %s", $time, msg);
    n_errors++;
  endtask

  // Present one instruction and update the model
  task automatic issue(input logic [XLEN-1:0] pc, a, r2, im, input alu_op_e op,
                       input logic [2:0] f3, input logic f7, input logic [4:0] d);
    exp_t e;
    logic keep, taken;
    @(posedge clk);
    #1;
    valid = 1'b1;
    npc   = pc;
    rs1   = a;
    rs2   = r2;
    imm   = im;
    aluop = op;
    func3 = f3;
    func7 = f7;
    rd    = d;
    keep = !armed_m || (pc == target_m);
    taken = keep && (op == BRANCH) && branch_cond(f3, a, r2);
    if (keep)
    begin
      e = '{model_result(pc, a, r2, im, op, f3, f7), taken, op == BRANCH,
            pc + {im[XLEN-2:0], 1'b0}, r2, d, cyc_count + 2};
      exp_q.push_back(e);
      pc_m = taken ? e.target : pc + 4;
      armed_m = taken;                              // Target instr may re-arm
      if (taken)
        target_m = e.target;
    end
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1 valid = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    idle(DRAIN);
    assert (exp_q.size() == 0)
      else report_failure($sformatf("%0d expected outputs never appeared", exp_q.size()));
    exp_q.delete();
    $display("test %s: %0d outputs checked, %0d errors", name, n_checks - chk0,
             n_errors - err0);
    chk0 = n_checks;
    err0 = n_errors;
  endtask

  task automatic check_output();
    exp_t e;
    n_checks++;
    assert (exp_q.size() > 0) else report_failure("o_valid high with no instruction expected");
    if (exp_q.size() > 0)
    begin
      e = exp_q.pop_front();
      assert (cyc_count == e.cyc)
        else report_failure($sformatf("output in cycle %0d, due in %0d", cyc_count, e.cyc));
      assert (o_result === e.result) else value_error("o_result", e.result, o_result);
      assert (o_branch_taken === e.taken)
        else value_error("o_branch_taken", e.taken, o_branch_taken);
      if (e.is_br)
        assert (o_branch_target === e.target)
          else value_error("o_branch_target", e.target, o_branch_target);
      assert (o_store_data === e.store) else value_error("o_store_data", e.store, o_store_data);
      assert (o_rd === e.rd) else value_error("o_rd", e.rd, o_rd);
    end
  endtask

  // Outputs sampled mid-cycle once reset is released
  always @(negedge clk)
  begin
    if (rst_n === 1'b1)
    begin
      if (o_valid === 1'b1)
        check_output();
      else
        assert (o_valid === 1'b0 && o_branch_taken === 1'b0)
          else report_failure("o_valid or o_branch_taken not low in an empty slot");
    end
  end

  initial
  begin
    int i, f, p;
    clk   = 1'b0;
    rst_n = 1'b0;
    valid = 1'b0;
    npc   = '0;
    rs1   = '0;
    rs2   = '0;
    imm   = '0;
    aluop = LDST;
    func3 = '0;
    func7 = 1'b0;
    rd    = '0;
    pa = '{32'd5, 32'hFFFF_FFFD, 32'd7, 32'd2, 32'd9, 32'h8000_0000};
    pb = '{32'd5, 32'd7, 32'hFFFF_FFFD, 32'd9, 32'd2, 32'h8000_0000};
    others = '{LDST, LUI, AUIPC, JAL, JALR};
    repeat (RST_CYC) @(posedge clk);
    #1 rst_n = 1'b1;
    idle(3);                                        // Outputs must stay quiet
    issue(pc_m, 32'd100, 32'd0, 32'd23, ITYPE, F3_ADD, 1'b0, 5'd1);
    finish_test("reset_and_latency");
    for (i = 0; i < N_ALU; i++)
      issue(pc_m, rand_bits(32), rand_bits(32), sext12(rand_bits(12)),
            rand_bits(1) ? RTYPE : ITYPE, rand_bits(3), rand_bits(1), rand_bits(5));
    finish_test("alu_random");
    for (i = 0; i < N_OTHER; i++)
      issue(pc_m, rand_bits(32), rand_bits(32),
            (others[i % 5] == LUI) ? {rand_bits(20), 12'h000} : sext12(rand_bits(12)),
            others[i % 5], rand_bits(3), 1'b0, rand_bits(5));
    finish_test("address_and_jump");
    for (f = 0; f < 8; f++)
      for (p = 0; p < 6; p++)
        issue(pc_m, pa[p], pb[p], sext12(rand_bits(12)), BRANCH, f, 1'b0, rand_bits(5));
    finish_test("branch_conditions");
    issue(pc_m, 32'd7, 32'd7, 32'h40, BRANCH, F3_BEQ, 1'b0, 5'd0); // Target npc+128
    for (i = 1; i <= 3; i++)
      issue(npc + 4, rand_bits(32), 32'd0, 32'd1, ITYPE, F3_ADD, 1'b0, 5'd3); // Wrong path
    issue(pc_m, 32'd10, 32'd0, 32'd5, ITYPE, F3_ADD, 1'b0, 5'd4);
    issue(pc_m, 32'd3, 32'd4, 32'd0, RTYPE, F3_OR, 1'b0, 5'd5);
    issue(pc_m, 32'd8, 32'd2, 32'd0, RTYPE, F3_ADD, 1'b1, 5'd6);
    finish_test("taken_squash");
    issue(pc_m, 32'd7, 32'd7, 32'h40, BRANCH, F3_BNE, 1'b0, 5'd0);
    for (i = 0; i < 3; i++)
      issue(pc_m, rand_bits(32), rand_bits(32), 32'd0, RTYPE, F3_XOR, 1'b0, rand_bits(5));
    finish_test("not_taken_flow");
    $display("total: %0d outputs checked, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
